/* design/lsu_cfg_pkg.sv */
package lsu_cfg_pkg;

	// load/store ops, 4-bit encoding seen at the top-level port
	typedef enum logic [3:0] {
		OP_LW  = 4'h0,
		OP_LH  = 4'h1,
		OP_LHU = 4'h2,
		OP_LB  = 4'h3,
		OP_LBU = 4'h4,
		OP_SW  = 4'h5,
		OP_SH  = 4'h6,
		OP_SB  = 4'h7
	} mem_op_e;

	// access size in bytes
	function automatic logic [2:0] op_bytes(input mem_op_e op);
		case (op)
			OP_LW, OP_SW: return 3'd4;
			OP_LH, OP_LHU, OP_SH: return 3'd2;
			default: return 3'd1;
		endcase
	endfunction

	function automatic logic op_is_store(input mem_op_e op);
		return op inside {OP_SW, OP_SH, OP_SB};
	endfunction

	// loads that sign-extend their result
	function automatic logic op_is_signed(input mem_op_e op);
		return op inside {OP_LW, OP_LH, OP_LB};
	endfunction

endpackage

/* design/bus_pkg.sv */
package bus_pkg;

	// default memory bus width in bytes, beats are aligned to it
	localparam int BUS_BYTES = 8;

	// bus sequencer states
	typedef enum logic [1:0] {
		IDLE      = 2'd0,
		ISSUE     = 2'd1,
		WAIT_RESP = 2'd2,
		DONE      = 2'd3
	} seq_state_e;

endpackage

/* design/lane_if.sv */
`timescale 1ns/1ps

// request fields, held for the whole operation
interface lane_cfg_if #(
	parameter int BUS_BYTES  = bus_pkg::BUS_BYTES,
	parameter int DATA_WIDTH = 32
);
	localparam int OFF_W = $clog2(BUS_BYTES);

	logic [OFF_W-1:0]      offset;
	logic [2:0]            size;
	logic                  is_signed;
	logic                  is_store;
	logic [DATA_WIDTH-1:0] wdata;
	logic                  two_beats;

	modport splitter(output offset, size, is_signed, is_store, wdata, two_beats);
	modport lane(input offset, size, is_store, wdata);
	modport seq(input is_store, two_beats);
	modport merger(input offset, size, is_signed, is_store);
endinterface

// beat traffic between the sequencer and the byte lanes
interface lane_beat_if #(
	parameter int BUS_BYTES = bus_pkg::BUS_BYTES
);
	logic                   beat_idx;
	logic                   resp_pulse;
	logic [BUS_BYTES*8-1:0] resp_data;
	// one byte and one strobe driven by each lane
	wire  [BUS_BYTES*8-1:0] wdata;
	wire  [BUS_BYTES-1:0]   wstrb;

	modport seq(output beat_idx, resp_pulse, resp_data, input wdata, wstrb);
	modport lane(input beat_idx, resp_pulse, resp_data, output wdata, wstrb);
endinterface

/* design/access_splitter.sv */
`timescale 1ns/1ps

module access_splitter import lsu_cfg_pkg::*; #(
	parameter int ADDR_WIDTH = 32,
	parameter int DATA_WIDTH = 32,
	parameter int BUS_BYTES  = bus_pkg::BUS_BYTES
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  req_valid,
	input  mem_op_e               req_op,
	input  logic [ADDR_WIDTH-1:0] req_addr,
	input  logic [DATA_WIDTH-1:0] req_wdata,
	input  logic                  idle,
	output logic                  req_ready,
	output logic                  start,
	output logic [ADDR_WIDTH-1:0] aligned_addr,
	lane_cfg_if.splitter          cfg
);
	localparam int OFF_W = $clog2(BUS_BYTES);

	logic [OFF_W-1:0]      req_offset;
	logic                  req_crosses;
	logic [OFF_W-1:0]      offset_q;
	logic [2:0]            size_q;
	logic                  signed_q;
	logic                  store_q;
	logic                  two_beats_q;
	logic [DATA_WIDTH-1:0] wdata_q;
	logic [ADDR_WIDTH-1:0] base_q;

	// one op in flight, accept only while the sequencer is idle
	assign req_ready = idle;
	assign start     = req_valid && req_ready;

	assign req_offset = req_addr[OFF_W-1:0];
	// runs past the end of the bus word, needs a second beat
	assign req_crosses = (int'(req_offset) + int'(op_bytes(req_op))) > BUS_BYTES;

	always_ff @(posedge clock) begin
		if (reset) begin
			store_q     <= 1'b0;
			two_beats_q <= 1'b0;
			size_q      <= 3'd0;
		end else if (start) begin
			store_q     <= op_is_store(req_op);
			two_beats_q <= req_crosses;
			size_q      <= op_bytes(req_op);
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			offset_q <= req_offset;
			signed_q <= op_is_signed(req_op);
			wdata_q  <= req_wdata;
			base_q   <= {req_addr[ADDR_WIDTH-1:OFF_W], {OFF_W{1'b0}}};
		end
	end

	assign cfg.offset    = offset_q;
	assign cfg.size      = size_q;
	assign cfg.is_signed = signed_q;
	assign cfg.is_store  = store_q;
	assign cfg.wdata     = wdata_q;
	assign cfg.two_beats = two_beats_q;
	assign aligned_addr  = base_q;

	// a start only from idle, and the sequencer leaves idle on the next cycle
	a_start_idle: assert property (@(posedge clock) disable iff (reset)
		start |-> idle ##1 !idle)
		else $error("start while sequencer not idle");

endmodule

/* design/byte_lane.sv */
`timescale 1ns/1ps

module byte_lane #(
	parameter int BUS_BYTES  = bus_pkg::BUS_BYTES,
	parameter int DATA_WIDTH = 32,
	parameter int LANE       = 0
) (
	input  logic       clock,
	input  logic       reset,
	lane_cfg_if.lane   cfg,
	lane_beat_if.lane  beat,
	output logic [7:0] lane_byte
);
	localparam int OFF_W = $clog2(BUS_BYTES);

	logic [OFF_W-1:0]      k;
	logic                  lane_beat;
	logic                  active;
	logic                  on_beat;
	logic                  write_en;
	logic                  capture;
	logic [DATA_WIDTH-1:0] store_shift;
	logic [7:0]            held;

	// data byte carried here wraps modulo the bus width
	assign k = OFF_W'(LANE) - cfg.offset;
	// lanes below the offset belong to the second beat
	assign lane_beat = OFF_W'(LANE) < cfg.offset;
	assign active    = int'(k) < int'(cfg.size);
	assign on_beat   = active && (beat.beat_idx == lane_beat);
	assign write_en  = on_beat && cfg.is_store;

	// store side
	assign store_shift = cfg.wdata >> (int'(k) * 8);
	assign beat.wdata[LANE*8 +: 8] = write_en ? store_shift[7:0] : 8'h00;
	assign beat.wstrb[LANE]        = write_en;

	// load side
	assign capture = beat.resp_pulse && on_beat && !cfg.is_store;

	always_ff @(posedge clock) begin
		if (capture)
			held <= beat.resp_data[LANE*8 +: 8];
	end

	// live byte during the response so the last beat reaches the merger at once
	assign lane_byte = capture ? beat.resp_data[LANE*8 +: 8] : held;

	// the sequencer reaches beat 1 only on an access that runs past the bus word
	a_beat1_crosses: assert property (@(posedge clock) disable iff (reset)
		beat.beat_idx |-> (int'(cfg.offset) + int'(cfg.size)) > BUS_BYTES)
		else $error("lane %0d sees beat 1 on a single-beat access", LANE);

endmodule

/* design/mem_sequencer.sv */
`timescale 1ns/1ps

module mem_sequencer import bus_pkg::*; #(
	parameter int ADDR_WIDTH = 32,
	parameter int BUS_BYTES  = bus_pkg::BUS_BYTES
) (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   start,
	input  logic [ADDR_WIDTH-1:0]  aligned_addr,
	input  logic                   resp_ready,
	input  logic                   mem_req_ready,
	input  logic                   mem_resp_valid,
	input  logic [BUS_BYTES*8-1:0] mem_resp_rdata,
	output logic                   idle,
	output logic                   last_done,
	output logic                   mem_req_valid,
	output logic                   mem_req_write,
	output logic [ADDR_WIDTH-1:0]  mem_req_addr,
	output logic [BUS_BYTES*8-1:0] mem_req_wdata,
	output logic [BUS_BYTES-1:0]   mem_req_wstrb,
	lane_cfg_if.seq                cfg,
	lane_beat_if.seq               beat
);
	seq_state_e state;
	seq_state_e state_next;
	logic       beat_q;
	logic       resp_hit;
	logic       last_beat;

	assign resp_hit  = (state == WAIT_RESP) && mem_resp_valid;
	assign last_beat = beat_q || !cfg.two_beats;
	// final response of the op, the merger registers the result on it
	assign last_done = resp_hit && last_beat;

	always_comb begin
		state_next = state;
		unique case (state)
			IDLE: begin
				if (start)
					state_next = ISSUE;
			end
			ISSUE: begin
				if (mem_req_ready)
					state_next = WAIT_RESP;
			end
			WAIT_RESP: begin
				if (mem_resp_valid)
					state_next = last_beat ? DONE : ISSUE;
			end
			DONE: begin
				// result sits in the merger until the consumer takes it
				if (resp_ready)
					state_next = IDLE;
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state  <= IDLE;
			beat_q <= 1'b0;
		end else begin
			state <= state_next;
			if (start)
				beat_q <= 1'b0;
			else if (resp_hit && !last_beat)
				beat_q <= 1'b1;
		end
	end

	assign idle          = (state == IDLE);
	assign mem_req_valid = (state == ISSUE);
	assign mem_req_write = cfg.is_store;
	// beat 1 goes to the next bus word
	assign mem_req_addr  = beat_q ? aligned_addr + ADDR_WIDTH'(BUS_BYTES) : aligned_addr;
	assign mem_req_wdata = beat.wdata;
	assign mem_req_wstrb = beat.wstrb;

	assign beat.beat_idx   = beat_q;
	assign beat.resp_pulse = resp_hit;
	assign beat.resp_data  = mem_resp_rdata;

	// lanes and splitter must keep a stalled request steady
	a_req_stable: assert property (@(posedge clock) disable iff (reset)
		mem_req_valid && !mem_req_ready |=> mem_req_valid
			&& $stable(mem_req_addr) && $stable(mem_req_write)
			&& $stable(mem_req_wdata) && $stable(mem_req_wstrb))
		else $error("memory request changed while stalled");

endmodule

/* design/load_merger.sv */
`timescale 1ns/1ps

module load_merger #(
	parameter int BUS_BYTES  = bus_pkg::BUS_BYTES,
	parameter int DATA_WIDTH = 32
) (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   last_done,
	input  logic [BUS_BYTES*8-1:0] lane_bytes,
	input  logic                   resp_ready,
	lane_cfg_if.merger             cfg,
	output logic                   resp_valid,
	output logic [DATA_WIDTH-1:0]  resp_rdata
);
	localparam int OFF_W      = $clog2(BUS_BYTES);
	localparam int DATA_BYTES = DATA_WIDTH / 8;

	logic [OFF_W-1:0]      lane_idx [DATA_BYTES];
	logic [DATA_WIDTH-1:0] ordered;
	logic [DATA_WIDTH-1:0] merged;
	logic                  sign_bit;

	// data byte j comes from lane (offset + j) mod BUS_BYTES
	for (genvar j = 0; j < DATA_BYTES; j++) begin : g_order
		assign lane_idx[j] = cfg.offset + OFF_W'(j);
		assign ordered[j*8 +: 8] = lane_bytes[int'(lane_idx[j])*8 +: 8];
	end

	// top bit of the accessed bytes
	always_comb begin
		case (cfg.size)
			3'd1: sign_bit = ordered[7];
			3'd2: sign_bit = ordered[15];
			default: sign_bit = ordered[DATA_WIDTH-1];
		endcase
	end

	always_comb begin
		merged = ordered;
		for (int j = 0; j < DATA_BYTES; j++) begin
			if (j >= int'(cfg.size))
				merged[j*8 +: 8] = {8{sign_bit && cfg.is_signed}};
		end
		// stores return zero
		if (cfg.is_store)
			merged = '0;
	end

	always_ff @(posedge clock) begin
		if (reset)
			resp_valid <= 1'b0;
		else if (last_done)
			resp_valid <= 1'b1;
		else if (resp_ready)
			resp_valid <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (last_done)
			resp_rdata <= merged;
	end

endmodule

/* design/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top import lsu_cfg_pkg::*; #(
	parameter int ADDR_WIDTH = 32,
	parameter int DATA_WIDTH = 32,
	parameter int BUS_BYTES  = bus_pkg::BUS_BYTES
) (
	input  logic                   clock,
	input  logic                   reset,
	// operation request
	input  logic                   req_valid,
	output logic                   req_ready,
	input  mem_op_e                req_op,
	input  logic [ADDR_WIDTH-1:0]  req_addr,
	input  logic [DATA_WIDTH-1:0]  req_wdata,
	// operation result
	output logic                   resp_valid,
	input  logic                   resp_ready,
	output logic [DATA_WIDTH-1:0]  resp_rdata,
	// memory bus
	output logic                   mem_req_valid,
	input  logic                   mem_req_ready,
	output logic                   mem_req_write,
	output logic [ADDR_WIDTH-1:0]  mem_req_addr,
	output logic [BUS_BYTES*8-1:0] mem_req_wdata,
	output logic [BUS_BYTES-1:0]   mem_req_wstrb,
	input  logic                   mem_resp_valid,
	input  logic [BUS_BYTES*8-1:0] mem_resp_rdata
);
	logic                   start;
	logic                   idle;
	logic                   last_done;
	logic [ADDR_WIDTH-1:0]  aligned_addr;
	logic [BUS_BYTES*8-1:0] lane_bytes;

	lane_cfg_if #(.BUS_BYTES(BUS_BYTES), .DATA_WIDTH(DATA_WIDTH)) cfg_if ();
	lane_beat_if #(.BUS_BYTES(BUS_BYTES)) beat_if ();

	access_splitter #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.DATA_WIDTH(DATA_WIDTH),
		.BUS_BYTES (BUS_BYTES)
	) u_splitter (
		.clock       (clock),
		.reset       (reset),
		.req_valid   (req_valid),
		.req_op      (req_op),
		.req_addr    (req_addr),
		.req_wdata   (req_wdata),
		.idle        (idle),
		.req_ready   (req_ready),
		.start       (start),
		.aligned_addr(aligned_addr),
		.cfg         (cfg_if.splitter)
	);

	mem_sequencer #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.BUS_BYTES (BUS_BYTES)
	) u_sequencer (
		.clock         (clock),
		.reset         (reset),
		.start         (start),
		.aligned_addr  (aligned_addr),
		.resp_ready    (resp_ready),
		.mem_req_ready (mem_req_ready),
		.mem_resp_valid(mem_resp_valid),
		.mem_resp_rdata(mem_resp_rdata),
		.idle          (idle),
		.last_done     (last_done),
		.mem_req_valid (mem_req_valid),
		.mem_req_write (mem_req_write),
		.mem_req_addr  (mem_req_addr),
		.mem_req_wdata (mem_req_wdata),
		.mem_req_wstrb (mem_req_wstrb),
		.cfg           (cfg_if.seq),
		.beat          (beat_if.seq)
	);

	// one lane per bus byte
	for (genvar i = 0; i < BUS_BYTES; i++) begin : g_lane
		byte_lane #(
			.BUS_BYTES (BUS_BYTES),
			.DATA_WIDTH(DATA_WIDTH),
			.LANE      (i)
		) u_lane (
			.clock    (clock),
			.reset    (reset),
			.cfg      (cfg_if.lane),
			.beat     (beat_if.lane),
			.lane_byte(lane_bytes[i*8 +: 8])
		);
	end

	load_merger #(
		.BUS_BYTES (BUS_BYTES),
		.DATA_WIDTH(DATA_WIDTH)
	) u_merger (
		.clock     (clock),
		.reset     (reset),
		.last_done (last_done),
		.lane_bytes(lane_bytes),
		.resp_ready(resp_ready),
		.cfg       (cfg_if.merger),
		.resp_valid(resp_valid),
		.resp_rdata(resp_rdata)
	);

endmodule

/* verif/lsu_checker.sv */
`timescale 1ns/1ps

module lsu_checker import lsu_cfg_pkg::*; #(
	parameter int ADDR_WIDTH = 32,
	parameter int DATA_WIDTH = 32,
	parameter int BUS_BYTES  = 8
) (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   req_valid,
	input  logic                   req_ready,
	input  mem_op_e                req_op,
	input  logic [ADDR_WIDTH-1:0]  req_addr,
	input  logic [DATA_WIDTH-1:0]  req_wdata,
	input  logic [DATA_WIDTH-1:0]  exp_rdata,
	input  logic                   resp_valid,
	input  logic                   resp_ready,
	input  logic [DATA_WIDTH-1:0]  resp_rdata,
	input  logic                   mem_req_valid,
	input  logic                   mem_req_ready,
	input  logic                   mem_req_write,
	input  logic [ADDR_WIDTH-1:0]  mem_req_addr,
	input  logic [BUS_BYTES*8-1:0] mem_req_wdata,
	input  logic [BUS_BYTES-1:0]   mem_req_wstrb,
	output int                     ops_done,
	output int                     error_count
);
	localparam int OFF_W = $clog2(BUS_BYTES);

	logic [7:0]             shadow [256];
	mem_op_e                cur_op;
	logic [ADDR_WIDTH-1:0]  cur_addr;
	logic [DATA_WIDTH-1:0]  cur_wdata;
	logic [DATA_WIDTH-1:0]  cur_exp;
	int                     beats;
	int                     op_errors;
	logic                   in_reset;
	logic                   stalled;
	logic [ADDR_WIDTH-1:0]  held_addr;
	logic                   held_write;
	logic [BUS_BYTES*8-1:0] held_wdata;
	logic [BUS_BYTES-1:0]   held_wstrb;

	function automatic int access_size(input mem_op_e op);
		case (op)
			OP_LW, OP_SW: return 4;
			OP_LH, OP_LHU, OP_SH: return 2;
			default: return 1;
		endcase
	endfunction

	function automatic logic is_write(input mem_op_e op);
		return op == OP_SW || op == OP_SH || op == OP_SB;
	endfunction

	// a second beat when the access runs past the bus word
	function automatic int beat_count(input logic [ADDR_WIDTH-1:0] addr, input int size);
		return (int'(addr[OFF_W-1:0]) + size > BUS_BYTES) ? 2 : 1;
	endfunction

	// lanes that carry data on the given beat
	function automatic logic [BUS_BYTES-1:0] lane_mask(input int off, input int size,
		input int beat);
		logic [BUS_BYTES-1:0] mask;
		int                   k;
		mask = '0;
		for (int i = 0; i < BUS_BYTES; i++) begin
			k = (i - off + BUS_BYTES) % BUS_BYTES;
			if (k < size && ((i < off) ? 1 : 0) == beat)
				mask[i] = 1'b1;
		end
		return mask;
	endfunction

	// little-endian load from the shadow copy, then extend
	function automatic logic [DATA_WIDTH-1:0] shadow_value(input mem_op_e op,
		input logic [ADDR_WIDTH-1:0] addr);
		logic [DATA_WIDTH-1:0] v;
		v = '0;
		for (int j = 0; j < access_size(op); j++)
			v[j*8 +: 8] = shadow[addr[7:0] + 8'(j)];
		if (op == OP_LB && v[7])
			v[DATA_WIDTH-1:8] = '1;
		if (op == OP_LH && v[15])
			v[DATA_WIDTH-1:16] = '1;
		return v;
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] want);
		$display("** Error: op %0d %s got %0h expected %0h", ops_done, name, got, want);
		error_count++;
		op_errors++;
	endtask

	task automatic report_failure(input string msg);
		$display("op %0d: %s", ops_done, msg);
		error_count++;
		op_errors++;
	endtask

	task automatic check_beat();
		logic [BUS_BYTES-1:0]  mask;
		logic [ADDR_WIDTH-1:0] want_addr;
		int                    off;
		int                    size;
		int                    k;
		off       = int'(cur_addr[OFF_W-1:0]);
		size      = access_size(cur_op);
		mask      = lane_mask(off, size, beats);
		want_addr = {cur_addr[ADDR_WIDTH-1:OFF_W], {OFF_W{1'b0}}}
			+ ADDR_WIDTH'(beats * BUS_BYTES);
		if (beats >= beat_count(cur_addr, size))
			report_failure("more bus requests than the access needs");
		if (mem_req_addr !== want_addr)
			report_mismatch("mem_req_addr", 64'(mem_req_addr), 64'(want_addr));
		if (mem_req_write !== is_write(cur_op))
			report_mismatch("mem_req_write", 64'(mem_req_write), 64'(is_write(cur_op)));
		if (mem_req_wstrb !== (is_write(cur_op) ? mask : '0))
			report_mismatch("mem_req_wstrb", 64'(mem_req_wstrb),
				64'(is_write(cur_op) ? mask : '0));
		for (int i = 0; i < BUS_BYTES; i++) begin
			k = (i - off + BUS_BYTES) % BUS_BYTES;
			if (is_write(cur_op) && mask[i] && mem_req_wdata[i*8 +: 8] !== cur_wdata[k*8 +: 8])
				report_mismatch($sformatf("mem_req_wdata lane %0d", i),
					64'(mem_req_wdata[i*8 +: 8]), 64'(cur_wdata[k*8 +: 8]));
		end
	endtask

	// sampled mid-cycle, each handshake lands on the next rising edge
	always @(negedge clock) begin
		if (reset) begin
			for (int a = 0; a < 256; a++)
				shadow[a] = 8'(a) ^ 8'hA5;
			ops_done    = 0;
			error_count = 0;
			beats       = 0;
			op_errors   = 0;
			stalled     = 1'b0;
			in_reset    = 1'b1;
		end else begin
			if (in_reset) begin
				in_reset = 1'b0;
				if (req_ready !== 1'b1)
					report_failure("req_ready is not high after reset");
				if (mem_req_valid !== 1'b0)
					report_failure("mem_req_valid is not low after reset");
				if (resp_valid !== 1'b0)
					report_failure("resp_valid is not low after reset");
			end

			if (req_valid && req_ready) begin
				cur_op    = req_op;
				cur_addr  = req_addr;
				cur_wdata = req_wdata;
				cur_exp   = exp_rdata;
				beats     = 0;
				op_errors = 0;
				if (!is_write(cur_op) && shadow_value(cur_op, cur_addr) !== cur_exp)
					report_failure("testdata expected value disagrees with the shadow memory");
				if (is_write(cur_op)) begin
					for (int j = 0; j < access_size(cur_op); j++)
						shadow[cur_addr[7:0] + 8'(j)] = cur_wdata[j*8 +: 8];
				end
			end

			if (mem_req_valid) begin
				if (stalled) begin
					if (mem_req_addr !== held_addr)
						report_mismatch("mem_req_addr during stall", 64'(mem_req_addr),
							64'(held_addr));
					if (mem_req_write !== held_write)
						report_mismatch("mem_req_write during stall", 64'(mem_req_write),
							64'(held_write));
					if (mem_req_wdata !== held_wdata)
						report_mismatch("mem_req_wdata during stall", 64'(mem_req_wdata),
							64'(held_wdata));
					if (mem_req_wstrb !== held_wstrb)
						report_mismatch("mem_req_wstrb during stall", 64'(mem_req_wstrb),
							64'(held_wstrb));
				end
				if (!mem_req_ready) begin
					stalled    = 1'b1;
					held_addr  = mem_req_addr;
					held_write = mem_req_write;
					held_wdata = mem_req_wdata;
					held_wstrb = mem_req_wstrb;
				end else begin
					stalled = 1'b0;
					check_beat();
					beats++;
				end
			end else begin
				if (stalled)
					report_failure("mem_req_valid dropped while the request was stalled");
				stalled = 1'b0;
			end

			if (resp_valid && resp_ready) begin
				if (beats != beat_count(cur_addr, access_size(cur_op)))
					report_failure($sformatf("saw %0d bus requests, the access needs %0d",
						beats, beat_count(cur_addr, access_size(cur_op))));
				if (resp_rdata !== cur_exp)
					report_mismatch("resp_rdata", 64'(resp_rdata), 64'(cur_exp));
				$display("op %0d %s addr %0h: %0d errors", ops_done, cur_op.name(),
					cur_addr, op_errors);
				ops_done++;
			end
		end
	end

endmodule

/* verif/tb_top.sv */
`timescale 1ns/1ps

module tb_top import lsu_cfg_pkg::*; ();
	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;
	localparam int BUS_BYTES  = 8;
	localparam int WAIT_LIMIT = 200;

	logic                   clock;
	logic                   reset;
	logic                   req_valid;
	logic                   req_ready;
	mem_op_e                req_op;
	logic [ADDR_WIDTH-1:0]  req_addr;
	logic [DATA_WIDTH-1:0]  req_wdata;
	logic [DATA_WIDTH-1:0]  exp_rdata;
	logic                   resp_valid;
	logic                   resp_ready = 1'b0;
	logic [DATA_WIDTH-1:0]  resp_rdata;
	logic                   mem_req_valid;
	logic                   mem_req_ready = 1'b0;
	logic                   mem_req_write;
	logic [ADDR_WIDTH-1:0]  mem_req_addr;
	logic [BUS_BYTES*8-1:0] mem_req_wdata;
	logic [BUS_BYTES-1:0]   mem_req_wstrb;
	logic                   mem_resp_valid = 1'b0;
	logic [BUS_BYTES*8-1:0] mem_resp_rdata = '0;

	// memory model state
	logic [7:0]             mem [256];
	logic                   mem_pending;
	int                     mem_delay;
	logic [ADDR_WIDTH-1:0]  mem_addr_q;

	int                     ops_done;
	int                     error_count;
	int                     ops_sent;
	bit                     aborted;

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// random stalls on the bus and on the result, one response per request
	always @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 256; i++)
				mem[i] <= 8'(i) ^ 8'hA5;
			mem_req_ready  <= 1'b0;
			mem_resp_valid <= 1'b0;
			mem_pending    <= 1'b0;
			mem_delay      <= 0;
			resp_ready     <= 1'b0;
		end else begin
			mem_req_ready  <= ($urandom % 4) != 0;
			resp_ready     <= ($urandom % 3) != 0;
			mem_resp_valid <= 1'b0;
			if (mem_req_valid && mem_req_ready) begin
				for (int b = 0; b < BUS_BYTES; b++) begin
					if (mem_req_write && mem_req_wstrb[b])
						mem[mem_req_addr[7:0] + 8'(b)] <= mem_req_wdata[b*8 +: 8];
				end
				mem_addr_q  <= mem_req_addr;
				mem_pending <= 1'b1;
				mem_delay   <= $urandom % 5;
			end else if (mem_pending) begin
				if (mem_delay == 0) begin
					for (int b = 0; b < BUS_BYTES; b++)
						mem_resp_rdata[b*8 +: 8] <= mem[mem_addr_q[7:0] + 8'(b)];
					mem_resp_valid <= 1'b1;
					mem_pending    <= 1'b0;
				end else begin
					mem_delay <= mem_delay - 1;
				end
			end
		end
	end

	task automatic run_op(input logic [3:0] op, input logic [31:0] addr,
		input logic [31:0] wdata, input logic [31:0] expv);
		int waited;
		@(posedge clock);
		req_valid <= 1'b1;
		req_op    <= mem_op_e'(op);
		req_addr  <= addr;
		req_wdata <= wdata;
		exp_rdata <= expv;
		waited = 0;
		@(posedge clock);
		while (!req_ready && waited < WAIT_LIMIT) begin
			@(posedge clock);
			waited++;
		end
		req_valid <= 1'b0;
		if (!req_ready) begin
			$display("timeout: req_ready never went high for op %0d", ops_sent);
			aborted = 1'b1;
			return;
		end
		ops_sent++;
		// result handshake, resp_ready toggles at random
		waited = 0;
		@(posedge clock);
		while (!(resp_valid && resp_ready) && waited < WAIT_LIMIT) begin
			@(posedge clock);
			waited++;
		end
		if (!(resp_valid && resp_ready)) begin
			if (!resp_valid)
				$display("timeout: resp_valid never went high for op %0d", ops_sent - 1);
			else
				$display("timeout: result of op %0d was never taken", ops_sent - 1);
			aborted = 1'b1;
		end
	endtask

	initial begin
		int          fd;
		int          code;
		string       line;
		logic [31:0] op_code;
		logic [31:0] f_addr;
		logic [31:0] f_wdata;
		logic [31:0] f_exp;
		void'($urandom(4));
		reset     = 1'b1;
		req_valid = 1'b0;
		req_op    = OP_LW;
		req_addr  = '0;
		req_wdata = '0;
		exp_rdata = '0;
		ops_sent  = 0;
		aborted   = 1'b0;
		repeat (5) @(posedge clock);
		reset <= 1'b0;

		fd = $fopen("verif/lsu_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open verif/lsu_testdata.txt");
			aborted = 1'b1;
		end
		while (!aborted && !$feof(fd)) begin
			code = $fgets(line, fd);
			// skip comment lines and blanks
			if (code != 0 && line[0] != "#"
				&& $sscanf(line, "%h %h %h %h", op_code, f_addr, f_wdata, f_exp) == 4)
				run_op(op_code[3:0], f_addr, f_wdata, f_exp);
		end
		if (fd != 0)
			$fclose(fd);

		repeat (2) @(posedge clock);
		$display("%0d of %0d operations checked, %0d errors", ops_done, ops_sent, error_count);
		if (aborted || error_count != 0 || ops_done != ops_sent || ops_done == 0)
			$display("Checks failed");
		else
			$display("All checks passed");
		$finish;
	end

	lsu_top #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.DATA_WIDTH(DATA_WIDTH),
		.BUS_BYTES (BUS_BYTES)
	) dut (
		.clock         (clock),
		.reset         (reset),
		.req_valid     (req_valid),
		.req_ready     (req_ready),
		.req_op        (req_op),
		.req_addr      (req_addr),
		.req_wdata     (req_wdata),
		.resp_valid    (resp_valid),
		.resp_ready    (resp_ready),
		.resp_rdata    (resp_rdata),
		.mem_req_valid (mem_req_valid),
		.mem_req_ready (mem_req_ready),
		.mem_req_write (mem_req_write),
		.mem_req_addr  (mem_req_addr),
		.mem_req_wdata (mem_req_wdata),
		.mem_req_wstrb (mem_req_wstrb),
		.mem_resp_valid(mem_resp_valid),
		.mem_resp_rdata(mem_resp_rdata)
	);

	lsu_checker #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.DATA_WIDTH(DATA_WIDTH),
		.BUS_BYTES (BUS_BYTES)
	) u_checker (
		.clock        (clock),
		.reset        (reset),
		.req_valid    (req_valid),
		.req_ready    (req_ready),
		.req_op       (req_op),
		.req_addr     (req_addr),
		.req_wdata    (req_wdata),
		.exp_rdata    (exp_rdata),
		.resp_valid   (resp_valid),
		.resp_ready   (resp_ready),
		.resp_rdata   (resp_rdata),
		.mem_req_valid(mem_req_valid),
		.mem_req_ready(mem_req_ready),
		.mem_req_write(mem_req_write),
		.mem_req_addr (mem_req_addr),
		.mem_req_wdata(mem_req_wdata),
		.mem_req_wstrb(mem_req_wstrb),
		.ops_done     (ops_done),
		.error_count  (error_count)
	);

endmodule

/* all.f */
design/lsu_cfg_pkg.sv
design/bus_pkg.sv
design/lane_if.sv
design/access_splitter.sv
design/byte_lane.sv
design/mem_sequencer.sv
design/load_merger.sv
design/lsu_top.sv
verif/lsu_checker.sv
verif/tb_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_top -o sim
./obj_dir/sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
	echo "simulation reported failures"
	exit 1
fi
if ! grep -q "All checks passed" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi

/* verif/lsu_testdata.txt */
# op addr wdata expected, all hex; op 0=lw 1=lh 2=lhu 3=lb 4=lbu 5=sw 6=sh 7=sb
# memory starts with each byte equal to its address xor a5
0 00000000 00000000 a6a7a4a5
0 00000084 00000000 22232021
1 00000002 00000000 ffffa6a7
2 0000000a 00000000 0000aeaf
3 00000013 00000000 ffffffb6
4 00000015 00000000 000000b0
3 0000008e 00000000 0000002b
0 00000005 00000000 ada2a3a0
0 00000026 00000000 8c8d8283
0 0000009f 00000000 0704053a
1 00000017 00000000 ffffbdb2
2 00000087 00000000 00002d22
5 00000040 12345678 00000000
0 00000040 00000000 12345678
5 00000045 cafef00d 00000000
0 00000045 00000000 cafef00d
1 00000047 00000000 ffffcafe
6 0000005f 0000beef 00000000
2 0000005f 00000000 0000beef
3 00000060 00000000 ffffffbe
7 00000062 aaaaaa7f 00000000
0 00000060 00000000 c67fc4be
6 0000006c 11118001 00000000
1 0000006c 00000000 ffff8001
